/* nib_exec.f */
logic/nib_pkg.sv
logic/nib_reg_port_if.sv
logic/nib_sequencer.sv
logic/nib_reg_slice.sv
logic/nib_read_mux.sv
logic/nib_alu.sv
logic/nib_exec_top.sv
verif/nib_clock_gen.sv
verif/nib_exec_assertions.sv
verif/nib_exec_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module nib_exec_tb -f nib_exec.f -o nib_exec_sim

./obj_dir/nib_exec_sim 2>&1 | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
    exit 0
else
    echo "simulation did not pass, see sim.log" >&2
    exit 1
fi

/* verif/nib_exec_tb.sv */
// Table-driven test of the execute unit that assumes a single master and full-word reference arithmetic
module nib_exec_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 100;
    localparam int RAND_ROWS  = 6;

    // One stimulus row with its expected result
    typedef struct {
        nib_pkg::nib_op_e op;
        logic [3:0]       rd;
        logic [3:0]       rs1;
        logic [3:0]       rs2;
        logic [11:0]      imm;
        logic [31:0]      exp_value;
        bit               fixed;
        bit               extra_start;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic [22:0] instr;
    logic        busy;
    logic        done;
    logic [31:0] result;
    logic [23:1] return_addr;

    row_t        rows[$];
    logic [31:0] model_regs [16];
    logic [31:0] lcg_state;
    bit          table_built;

    nib_clock_gen #(.PERIOD_NS (CLK_PERIOD), .RESET_CYCLES (4)) u_clk (.clk, .rst_n);

    nib_exec_top u_dut (
        .clk, .rst_n, .start, .instr, .busy, .done, .result, .return_addr
    );

    bind nib_exec_top nib_exec_assertions u_assert (
        .clk (clk), .rst_n (rst_n), .busy (busy), .done (done)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic add_row(input nib_pkg::nib_op_e op, input int rd, input int rs1,
                           input int rs2, input logic [11:0] imm,
                           input logic [31:0] exp_value, input bit fixed, input bit extra);
        row_t r;
        r.op          = op;
        r.rd          = 4'(rd);
        r.rs1         = 4'(rs1);
        r.rs2         = 4'(rs2);
        r.imm         = imm;
        r.exp_value   = exp_value;
        r.fixed       = fixed;
        r.extra_start = extra;
        rows.push_back(r);
    endtask

    // Word-level reference for every supported op
    function automatic logic [31:0] model_alu(nib_pkg::nib_op_e op, logic [31:0] a,
                                              logic [31:0] b, logic [11:0] imm);
        case (op)
            nib_pkg::OP_ADD:  return a + b;
            nib_pkg::OP_SUB:  return a - b;
            nib_pkg::OP_AND:  return a & b;
            nib_pkg::OP_OR:   return a | b;
            nib_pkg::OP_XOR:  return a ^ b;
            default:          return a + {{20{imm[11]}}, imm};
        endcase
    endfunction

    function automatic bit rd_writable(logic [3:0] rd);
        return (rd != 4'd0) && (rd != 4'd3) && (rd != 4'd4);
    endfunction

    // Built through the view that matches the op
    function automatic nib_pkg::nib_instr_u encode_instr(row_t r);
        nib_pkg::nib_instr_u w;
        if (r.op == nib_pkg::OP_ADDI) begin
            w.i.op  = r.op;
            w.i.rd  = r.rd;
            w.i.rs1 = r.rs1;
            w.i.imm = r.imm;
        end else begin
            w.r.op     = r.op;
            w.r.rd     = r.rd;
            w.r.rs1    = r.rs1;
            w.r.unused = '0;
            w.r.rs2    = r.rs2;
        end
        return w;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("TESTS FAILED");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic apply_row(input row_t r);
        logic [31:0]         expected;
        nib_pkg::nib_instr_u stray;
        if (r.fixed) begin
            expected = r.exp_value;
        end else begin
            expected = model_alu(r.op, model_regs[r.rs1], model_regs[r.rs2], r.imm);
        end
        while (busy) @(negedge clk);
        start = 1'b1;
        instr = encode_instr(r);
        @(negedge clk);
        // Accepted start raises busy on the next edge
        check_value("busy", {31'b0, busy}, 32'd1);
        // Second strobe lands while busy and must be dropped
        if (r.extra_start) begin
            stray.i.op  = nib_pkg::OP_ADDI;
            stray.i.rd  = r.rd;
            stray.i.rs1 = 4'd0;
            stray.i.imm = r.imm ^ 12'h5A5;
            instr = stray;
            @(negedge clk);
        end
        start = 1'b0;
        instr = '0;
        while (!done) @(negedge clk);
        check_value("result", result, expected);
        if (rd_writable(r.rd)) begin
            model_regs[r.rd] = expected;
        end
        check_value("return_addr", {9'b0, return_addr}, {9'b0, model_regs[1][23:1]});
    endtask

    // Ends a stuck run, sized from the table
    initial begin
        wait (table_built);
        #((rows.size() * 20 + 20) * CLK_PERIOD);
        $display("timeout waiting for done");
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] rnd;
        start     = 1'b0;
        instr     = '0;
        lcg_state = 32'd95;
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = '0;
        end
        model_regs[3] = nib_pkg::GP_VALUE;
        model_regs[4] = nib_pkg::TP_VALUE;

        // Fixed expectations first
        add_row(nib_pkg::OP_ADDI, 5, 0, 0, 12'h123, 32'h0000_0123, 1, 0);
        add_row(nib_pkg::OP_ADDI, 6, 0, 0, 12'h800, 32'hFFFF_F800, 1, 0);
        add_row(nib_pkg::OP_ADD,  7, 3, 4, 12'h000, 32'h0900_0400, 1, 0);
        add_row(nib_pkg::OP_ADDI, 8, 0, 0, 12'hFFF, 32'hFFFF_FFFF, 1, 0);
        add_row(nib_pkg::OP_ADDI, 9, 0, 0, 12'h7FF, 32'h0000_07FF, 1, 0);
        // Carry chain and borrow
        add_row(nib_pkg::OP_ADD,  9, 9, 9, 12'h000, '0, 0, 0);
        add_row(nib_pkg::OP_ADDI, 9, 9, 0, 12'h001, '0, 0, 0);
        add_row(nib_pkg::OP_ADD,  10, 9, 9, 12'h000, '0, 0, 1);
        add_row(nib_pkg::OP_SUB,  11, 0, 5, 12'h000, '0, 0, 0);
        add_row(nib_pkg::OP_SUB,  12, 5, 9, 12'h000, '0, 0, 0);
        // Logic ops
        add_row(nib_pkg::OP_AND,  13, 6, 9, 12'h000, '0, 0, 0);
        add_row(nib_pkg::OP_OR,   14, 5, 6, 12'h000, '0, 0, 0);
        add_row(nib_pkg::OP_XOR,  15, 9, 8, 12'h000, '0, 0, 0);
        // Writes to hardwired registers, then read them back
        add_row(nib_pkg::OP_ADDI, 3, 0, 0, 12'h555, '0, 0, 0);
        add_row(nib_pkg::OP_ADD,  0, 5, 5, 12'h000, '0, 0, 0);
        add_row(nib_pkg::OP_ADDI, 4, 8, 0, 12'h0F0, '0, 0, 0);
        add_row(nib_pkg::OP_ADD,  7, 3, 4, 12'h000, '0, 0, 0);
        add_row(nib_pkg::OP_OR,   2, 0, 3, 12'h000, '0, 0, 0);
        // Return address source
        add_row(nib_pkg::OP_ADDI, 1, 0, 0, 12'h7FE, '0, 0, 0);
        add_row(nib_pkg::OP_ADD,  1, 1, 3, 12'h000, '0, 0, 0);
        // Random immediates
        for (int i = 0; i < RAND_ROWS; i++) begin
            rnd = lcg_next();
            add_row(nib_pkg::OP_ADDI, (i % 2 == 0) ? 1 : 12, 9, 0, rnd[27:16], '0, 0, i == 3);
        end
        add_row(nib_pkg::OP_SUB, 13, 1, 12, 12'h000, '0, 0, 0);
        table_built = 1'b1;

        wait (rst_n);
        @(negedge clk);
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        if (u_dut.u_assert.fail_count != 0) begin
            $display("handshake assertion failed %0d times", u_dut.u_assert.fail_count);
            $display("TESTS FAILED");
            $fatal(1, "handshake assertion failures");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

/* verif/nib_exec_assertions.sv */
// Handshake properties sampled on the rising clock, expects an asynchronous active-low reset on rst_n
module nib_exec_assertions (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic done
);
    timeunit 1ns;
    timeprecision 100ps;

    // Number of property failures so far
    int unsigned fail_count = 0;

    // done is a one-cycle pulse
    done_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) done |=> !done
    ) else begin
        fail_count++;
        $error("done stayed high for more than one cycle");
    end

    // Handshake outputs quiet while in reset
    quiet_in_reset: assert property (
        @(posedge clk) !rst_n |-> (!busy && !done)
    ) else begin
        fail_count++;
        $error("busy or done high during reset");
    end

    // Unit is already idle when done pulses
    idle_at_done: assert property (
        @(posedge clk) disable iff (!rst_n) done |-> !busy
    ) else begin
        fail_count++;
        $error("busy still high while done pulses");
    end

endmodule

/* verif/nib_clock_gen.sv */
// Free-running clock from time zero with rst_n released on a falling edge after RESET_CYCLES rising edges
module nib_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    // Square wave, low first
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release away from the active edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* logic/nib_exec_top.sv */
// Execute unit top level where start is honoured only while busy is low and result is held only until the next operation
module nib_exec_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  start,
    input  logic [$bits(nib_pkg::nib_instr_u)-1:0] instr,
    output logic                                  busy,
    output logic                                  done,
    output logic [nib_pkg::WORD_W-1:0]            result,
    output logic [23:1]                           return_addr
);

    nib_pkg::nib_instr_u               instr_w;
    logic [nib_pkg::REG_ADDR_BITS-1:0] rs1;
    logic [nib_pkg::REG_ADDR_BITS-1:0] rs2;
    nib_pkg::nib_op_e                  op;
    logic [nib_pkg::IMM_W-1:0]         imm;
    logic                              first_nib;
    logic                              alu_en;
    logic [nib_pkg::NIB_W-1:0]         slice_nibs [nib_pkg::NUM_REGS];
    logic [nib_pkg::WORD_W-1:0]        slice_vals [nib_pkg::NUM_REGS];
    logic [nib_pkg::NIB_W-1:0]         nib_rs1;
    logic [nib_pkg::NIB_W-1:0]         nib_rs2;
    logic [nib_pkg::NIB_W-1:0]         nib_rd;

    nib_reg_port_if reg_port ();

    assign instr_w          = instr;
    // ALU nibble goes back to the slices
    assign reg_port.data_rd = nib_rd;

    nib_sequencer u_seq (
        .clk, .rst_n, .start, .instr (instr_w), .busy, .done,
        .rs1, .rs2, .op, .imm, .first_nib, .alu_en, .reg_port (reg_port)
    );

    // Storage only for writable registers
    for (genvar i = 0; i < nib_pkg::NUM_REGS; i++) begin : g_reg
        if (i == 0 || i == nib_pkg::REG_GP || i == nib_pkg::REG_TP) begin : g_hard
            assign slice_nibs[i] = '0;
            assign slice_vals[i] = '0;
        end else begin : g_slice
            nib_reg_slice #(.REG_INDEX (i)) u_slice (
                .clk, .rst_n, .reg_port (reg_port),
                .nib_out (slice_nibs[i]), .value (slice_vals[i])
            );
        end
    end

    nib_read_mux u_mux (
        .slice_nibs, .counter (reg_port.counter), .rs1, .rs2, .nib_rs1, .nib_rs2
    );

    nib_alu u_alu (
        .clk, .rst_n, .alu_en, .first_nib, .counter (reg_port.counter),
        .op, .imm, .nib_rs1, .nib_rs2, .nib_rd, .result
    );

    // Return address from x1
    assign return_addr = slice_vals[1][23:1];

endmodule

/* logic/nib_alu.sv */
// Serial nibble ALU with result valid only after a full sweep and the 12-bit immediate sign extended from nibble 3 up
module nib_alu (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      alu_en,
    input  logic                      first_nib,
    input  logic [nib_pkg::CNT_W-1:0] counter,
    input  nib_pkg::nib_op_e          op,
    input  logic [nib_pkg::IMM_W-1:0] imm,
    input  logic [nib_pkg::NIB_W-1:0] nib_rs1,
    input  logic [nib_pkg::NIB_W-1:0] nib_rs2,
    output logic [nib_pkg::NIB_W-1:0] nib_rd,
    output logic [nib_pkg::WORD_W-1:0] result
);

    logic [nib_pkg::NIB_W-1:0] imm_nib;
    logic [nib_pkg::NIB_W-1:0] opnd_b;
    logic                      carry_q;
    logic                      carry_in;
    logic [nib_pkg::NIB_W:0]   sum;

    // Immediate nibbles 0..2 then sign copies
    assign imm_nib = (counter < nib_pkg::IMM_W / nib_pkg::NIB_W) ?
                     imm[nib_pkg::NIB_W * counter +: nib_pkg::NIB_W] :
                     {nib_pkg::NIB_W{imm[nib_pkg::IMM_W-1]}};

    always_comb begin
        opnd_b = (op == nib_pkg::OP_ADDI) ? imm_nib : nib_rs2;
        // Subtract as add of inverted operand plus one
        if (op == nib_pkg::OP_SUB) begin
            opnd_b = ~opnd_b;
        end
        carry_in = first_nib ? (op == nib_pkg::OP_SUB) : carry_q;
        sum      = {1'b0, nib_rs1} + {1'b0, opnd_b} + {{nib_pkg::NIB_W{1'b0}}, carry_in};
        case (op)
            nib_pkg::OP_AND: nib_rd = nib_rs1 & opnd_b;
            nib_pkg::OP_OR:  nib_rd = nib_rs1 | opnd_b;
            nib_pkg::OP_XOR: nib_rd = nib_rs1 ^ opnd_b;
            default:         nib_rd = sum[nib_pkg::NIB_W-1:0];
        endcase
    end

    // Carry between nibbles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            carry_q <= 1'b0;
        end else if (alu_en) begin
            carry_q <= sum[nib_pkg::NIB_W];
        end
    end

    // Low nibble first so the word lines up after eight shifts
    always_ff @(posedge clk) begin
        if (alu_en) begin
            result <= {nib_rd, result[nib_pkg::WORD_W-1:nib_pkg::NIB_W]};
        end
    end

endmodule

/* logic/nib_read_mux.sv */
// Combinational operand select where entries 0, 3 and 4 of slice_nibs are ignored and replaced by constants
module nib_read_mux (
    input  logic [nib_pkg::NIB_W-1:0]         slice_nibs [nib_pkg::NUM_REGS],
    input  logic [nib_pkg::CNT_W-1:0]         counter,
    input  logic [nib_pkg::REG_ADDR_BITS-1:0] rs1,
    input  logic [nib_pkg::REG_ADDR_BITS-1:0] rs2,
    output logic [nib_pkg::NIB_W-1:0]         nib_rs1,
    output logic [nib_pkg::NIB_W-1:0]         nib_rs2
);

    logic [nib_pkg::NIB_W-1:0] gp_nib;
    logic [nib_pkg::NIB_W-1:0] tp_nib;
    logic [nib_pkg::NIB_W-1:0] reg_access [nib_pkg::NUM_REGS];

    // Constant nibbles picked by position
    assign gp_nib = nib_pkg::GP_VALUE[nib_pkg::NIB_W * counter +: nib_pkg::NIB_W];
    assign tp_nib = nib_pkg::TP_VALUE[nib_pkg::NIB_W * counter +: nib_pkg::NIB_W];

    // Full table of current nibbles
    always_comb begin
        for (int i = 0; i < nib_pkg::NUM_REGS; i++) begin
            if (i == 0) begin
                // x0 always zero
                reg_access[i] = '0;
            end else if (i == nib_pkg::REG_GP) begin
                reg_access[i] = gp_nib;
            end else if (i == nib_pkg::REG_TP) begin
                reg_access[i] = tp_nib;
            end else begin
                reg_access[i] = slice_nibs[i];
            end
        end
    end

    // Two read ports
    assign nib_rs1 = reg_access[rs1];
    assign nib_rs2 = reg_access[rs2];

endmodule

/* logic/nib_reg_slice.sv */
// One rotating 32-bit register that needs a counter which has run from reset to keep nibble k facing counter k
module nib_reg_slice #(
    parameter int REG_INDEX = 1
) (
    input  logic                               clk,
    input  logic                               rst_n,
    nib_reg_port_if.slice                      reg_port,
    output logic [nib_pkg::NIB_W-1:0]          nib_out,
    output logic [nib_pkg::WORD_W-1:0]         value
);

    logic [nib_pkg::WORD_W-1:0]   word_q;
    logic [2*nib_pkg::WORD_W-1:0] word_dbl;
    logic [nib_pkg::NIB_W-1:0]    nib_in;
    logic                         sel;

    // Write hits only this register
    assign sel = reg_port.wr_en && (reg_port.rd == REG_INDEX);

    // New nibble replaces the one leaving the bottom
    assign nib_in = sel ? reg_port.data_rd : word_q[nib_pkg::NIB_W-1:0];

    // Rotate right one nibble every clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_q <= '0;
        end else begin
            word_q <= {nib_in, word_q[nib_pkg::WORD_W-1:nib_pkg::NIB_W]};
        end
    end

    // Bottom nibble is nibble number counter
    assign nib_out = word_q[nib_pkg::NIB_W-1:0];

    // Undo the rotation for the full word
    assign word_dbl = {word_q, word_q};
    assign value    = word_dbl[nib_pkg::WORD_W - nib_pkg::NIB_W * reg_port.counter
                               +: nib_pkg::WORD_W];

endmodule

/* logic/nib_sequencer.sv */
// Free-running nibble counter and start handshake where a start during busy is dropped and latency is 1 to 8 cycles plus a sweep
module nib_sequencer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start,
    input  nib_pkg::nib_instr_u               instr,
    output logic                              busy,
    output logic                              done,
    output logic [nib_pkg::REG_ADDR_BITS-1:0] rs1,
    output logic [nib_pkg::REG_ADDR_BITS-1:0] rs2,
    output nib_pkg::nib_op_e                  op,
    output logic [nib_pkg::IMM_W-1:0]         imm,
    output logic                              first_nib,
    output logic                              alu_en,
    nib_reg_port_if.seq                       reg_port
);

    logic [nib_pkg::CNT_W-1:0] cnt_q;
    logic                      armed_q;
    logic                      run_q;
    logic                      done_q;
    nib_pkg::nib_instr_u       instr_q;
    logic                      accept;
    logic                      sweep_start;
    logic                      sweep_end;
    logic                      active;
    logic                      rd_writable;

    assign busy        = armed_q | run_q;
    assign accept      = start & ~busy;
    // Waiting for counter 0 to line up with nibble 0
    assign sweep_start = armed_q & (cnt_q == '0);
    assign sweep_end   = run_q & (cnt_q == nib_pkg::LAST_NIB);
    assign active      = run_q | sweep_start;

    // Counter never stops so registers stay aligned
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q   <= '0;
            armed_q <= 1'b0;
            run_q   <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            cnt_q  <= (cnt_q == nib_pkg::LAST_NIB) ? '0 : cnt_q + 1'b1;
            done_q <= sweep_end;
            if (accept) begin
                armed_q <= 1'b1;
            end else if (sweep_start) begin
                armed_q <= 1'b0;
            end
            if (sweep_start) begin
                run_q <= 1'b1;
            end else if (sweep_end) begin
                run_q <= 1'b0;
            end
        end
    end

    // Instruction held until the next accepted start
    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= instr;
        end
    end

    // Decode through the member that matches the op
    always_comb begin
        op  = instr_q.r.op;
        rs1 = instr_q.r.rs1;
        if (op == nib_pkg::OP_ADDI) begin
            rs2 = '0;
            imm = instr_q.i.imm;
        end else begin
            rs2 = instr_q.r.rs2;
            imm = '0;
        end
    end

    // x0, gp and tp still run but never write
    assign rd_writable = (instr_q.r.rd != '0) && (instr_q.r.rd != nib_pkg::REG_GP) &&
                         (instr_q.r.rd != nib_pkg::REG_TP);

    assign first_nib        = sweep_start;
    assign alu_en           = active;
    assign done             = done_q;
    assign reg_port.counter = cnt_q;
    assign reg_port.wr_en   = active & rd_writable;
    assign reg_port.rd      = instr_q.r.rd;

endmodule

/* logic/nib_reg_port_if.sv */
// Sequencer to register slice port where data_rd is assigned by the top level from the ALU
interface nib_reg_port_if;

    // Nibble index facing every register
    logic [nib_pkg::CNT_W-1:0]         counter;
    logic                              wr_en;
    logic [nib_pkg::REG_ADDR_BITS-1:0] rd;
    // Result nibble from the ALU
    logic [nib_pkg::NIB_W-1:0]         data_rd;

    modport seq   (output counter, wr_en, rd);
    modport slice (input counter, wr_en, rd, data_rd);

endinterface

/* logic/nib_pkg.sv */
// Sizes, opcodes and hardwired constants for a nibble-serial RV32E subset whose 23-bit instruction word is not RISC-V encoded
package nib_pkg;

    // Register file geometry with 16 architectural registers
    localparam int NUM_REGS      = 16;
    localparam int REG_ADDR_BITS = 4;

    // One nibble per clock and eight nibbles per word
    localparam int NIB_W    = 4;
    localparam int NUM_NIBS = 8;
    localparam int CNT_W    = 3;
    localparam int WORD_W   = NIB_W * NUM_NIBS;
    localparam int IMM_W    = 12;

    // Counter value of the final nibble in a sweep
    localparam logic [CNT_W-1:0] LAST_NIB = CNT_W'(NUM_NIBS - 1);

    // Hardwired registers with no storage behind them
    localparam int REG_GP = 3;
    localparam int REG_TP = 4;
    localparam logic [WORD_W-1:0] GP_VALUE = 32'h0100_0400;
    localparam logic [WORD_W-1:0] TP_VALUE = 32'h0800_0000;

    // Supported operations
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_ADDI = 3'd5
    } nib_op_e;

    // Register form with rs2 in the low bits
    typedef struct packed {
        nib_op_e                  op;
        logic [REG_ADDR_BITS-1:0] rd;
        logic [REG_ADDR_BITS-1:0] rs1;
        logic [7:0]               unused;
        logic [REG_ADDR_BITS-1:0] rs2;
    } nib_instr_r_t;

    // Immediate form with the immediate in the low bits
    typedef struct packed {
        nib_op_e                  op;
        logic [REG_ADDR_BITS-1:0] rd;
        logic [REG_ADDR_BITS-1:0] rs1;
        logic [IMM_W-1:0]         imm;
    } nib_instr_i_t;

    // Same 23 bits and two decodings
    typedef union packed {
        nib_instr_r_t r;
        nib_instr_i_t i;
    } nib_instr_u;

endpackage
